//--- src/core_io_pkg.sv
// Bus widths, I/O address map, reset values, interrupt bits and shared structs

package core_io_pkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////
  localparam int IO_ADDR_W     = 6;
  localparam int WORD_W        = 32;
  localparam int STRB_W        = WORD_W / 8;
  localparam int BC_ADDR_W     = 15;
  localparam int BC_FIFO_DEPTH = 16;
  localparam int TAG_W         = 5;
  localparam int INT_W         = 16;

  localparam logic [WORD_W-1:0] TIMER_STEP_RESET = 32'd1;
  // Everything used is enabled except the timer
  localparam logic [INT_W-1:0]  INT_MASK_RESET   = 16'h011E;

  //////////////////////////////
  // Address map
  //////////////////////////////
  localparam logic [IO_ADDR_W-1:0] ADDR_SEND_DESC_L    = 6'h02;
  localparam logic [IO_ADDR_W-1:0] ADDR_SEND_DESC_H    = 6'h03;
  localparam logic [IO_ADDR_W-1:0] ADDR_TIMER_STEP     = 6'h07;
  localparam logic [IO_ADDR_W-1:0] ADDR_DRAM_FLAG_WR   = 6'h08;
  localparam logic [IO_ADDR_W-1:0] ADDR_SEND_DESC_TYPE = 6'h0A;
  localparam logic [IO_ADDR_W-1:0] ADDR_RD_DESC_STRB   = 6'h0B;
  localparam logic [IO_ADDR_W-1:0] ADDR_DRAM_FLAG_CLR  = 6'h0C;
  localparam logic [IO_ADDR_W-1:0] ADDR_INT_MASK       = 6'h0E;
  localparam logic [IO_ADDR_W-1:0] ADDR_INT_ACK        = 6'h0F;
  localparam logic [IO_ADDR_W-1:0] ADDR_BC_MASK        = 6'h12;
  localparam logic [IO_ADDR_W-1:0] ADDR_BC_EQUAL       = 6'h13;
  localparam logic [IO_ADDR_W-1:0] ADDR_BC_FIFO_EN     = 6'h14;
  localparam logic [IO_ADDR_W-1:0] ADDR_BC_RD_STRB     = 6'h15;
  localparam logic [IO_ADDR_W-1:0] ADDR_REWR_DESC_L    = 6'h16;
  localparam logic [IO_ADDR_W-1:0] ADDR_REWR_DESC_H    = 6'h17;

  // Read side lives in the upper half
  localparam logic [IO_ADDR_W-1:0] ADDR_RD_DESC_L      = 6'h20;
  localparam logic [IO_ADDR_W-1:0] ADDR_RD_DESC_H      = 6'h21;
  localparam logic [IO_ADDR_W-1:0] ADDR_RD_DRAM_FLAGS  = 6'h22;
  localparam logic [IO_ADDR_W-1:0] ADDR_RD_STATUS      = 6'h23;
  localparam logic [IO_ADDR_W-1:0] ADDR_RD_INT_FLAGS   = 6'h27;
  localparam logic [IO_ADDR_W-1:0] ADDR_RD_MASK        = 6'h28;
  localparam logic [IO_ADDR_W-1:0] ADDR_RD_BC_MASK     = 6'h32;
  localparam logic [IO_ADDR_W-1:0] ADDR_RD_BC_EQUAL    = 6'h33;
  localparam logic [IO_ADDR_W-1:0] ADDR_RD_BC_ADDR     = 6'h34;

  // Interrupt flag bits, same positions in the ack word
  localparam int INT_TIMER   = 0;
  localparam int INT_IN_DESC = 1;
  localparam int INT_DRAM    = 2;
  localparam int INT_BC_MSG  = 3;
  localparam int INT_POKE    = 4;
  localparam int INT_BC_ERR  = 8;

  //////////////////////////////
  // Shared types
  //////////////////////////////
  typedef struct packed {
    logic                 wr;
    logic [IO_ADDR_W-1:0] addr;
    logic [WORD_W-1:0]    data;
    logic [STRB_W-1:0]    strb;
  } io_req_t;

  typedef struct packed {
    logic [3:0]  dtype;
    logic [59:0] payload;
  } desc_t;

  typedef struct packed {
    logic [WORD_W-1:0]    timer_step;
    logic [INT_W-1:0]     int_mask;
    logic [BC_ADDR_W-1:0] bc_mask;
    logic [BC_ADDR_W-1:0] bc_equal;
    logic                 bc_fifo_en;
  } io_cfg_t;

  // Single-cycle strobes with the write word that came with them
  typedef struct packed {
    logic              timer_restart;
    logic              flag_wr;
    logic              flag_clr;
    logic              int_ack;
    logic              bc_pop;
    logic              desc_release;
    logic [WORD_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } io_cmd_t;

  typedef struct packed {
    logic [6:0] rsvd_hi;
    logic       bc_err;
    logic [2:0] rsvd_lo;
    logic       poke;
    logic       bc_msg;
    logic       dram;
    logic       in_desc;
    logic       timer;
  } int_flags_t;

  localparam io_cfg_t CFG_RESET = '{
    timer_step: TIMER_STEP_RESET,
    int_mask:   INT_MASK_RESET,
    bc_mask:    '0,
    bc_equal:   '0,
    bc_fifo_en: 1'b0
  };

  // Merge the strobed bytes of a new word into an old one
  function automatic logic [WORD_W-1:0] apply_strb(
    input logic [WORD_W-1:0] old_word,
    input logic [WORD_W-1:0] new_word,
    input logic [STRB_W-1:0] strb
  );
    logic [WORD_W-1:0] res;
    res = old_word;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i])
        res[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return res;
  endfunction

endpackage

//--- src/sync_fifo.sv
// First-word-fall-through synchronous FIFO with clear
`timescale 1ns/1ps

module sync_fifo #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             clear,
  input  logic             din_valid,
  input  logic [WIDTH-1:0] din,
  output logic             din_ready,
  output logic             dout_valid,
  output logic [WIDTH-1:0] dout,
  input  logic             dout_ready
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             push;
  logic             pop;

  assign din_ready  = (count != DEPTH[AW:0]);
  assign dout_valid = (count != '0);
  assign dout       = mem[rd_ptr];
  assign push       = din_valid && din_ready;
  assign pop        = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= din;
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  a_no_empty_pop: assert property (@(posedge clk) disable iff (rst || clear)
    dout_ready |-> dout_valid);

endmodule

//--- src/io_reg_file.sv
// I/O write decoder with configuration registers, outgoing descriptor and command strobes
`timescale 1ns/1ps

module io_reg_file import core_io_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    req_valid,
  input  io_req_t req,
  output logic    req_ready,
  output desc_t   out_desc,
  output logic    out_desc_valid,
  input  logic    out_desc_ready,
  output io_cfg_t cfg,
  output io_cmd_t cmd,
  output logic    in_desc_taken
);

  logic              send_addr;
  logic              wr_fire;
  logic              rewr_wr;
  logic [WORD_W-1:0] desc_lo_new;
  logic [WORD_W-1:0] desc_hi_new;
  logic [WORD_W-1:0] step_new;
  logic [WORD_W-1:0] mask_new;

  //////////////////////////////
  // Handshake
  //////////////////////////////
  assign send_addr = (req.addr == ADDR_SEND_DESC_L) ||
                     (req.addr == ADDR_SEND_DESC_H) ||
                     (req.addr == ADDR_SEND_DESC_TYPE);

  // Only send writes wait on a descriptor that has not been taken
  assign req_ready = !(req_valid && req.wr && send_addr &&
                       out_desc_valid && !out_desc_ready);
  assign wr_fire   = req_valid && req_ready && req.wr;
  assign rewr_wr   = wr_fire && ((req.addr == ADDR_REWR_DESC_L) ||
                                 (req.addr == ADDR_REWR_DESC_H));

  assign desc_lo_new = apply_strb(out_desc.payload[31:0], req.data, req.strb);
  assign desc_hi_new = apply_strb({4'b0000, out_desc.payload[59:32]}, req.data, req.strb);
  assign step_new    = apply_strb(cfg.timer_step, req.data, req.strb);
  assign mask_new    = apply_strb({{(WORD_W-INT_W){1'b0}}, cfg.int_mask}, req.data, req.strb);

  //////////////////////////////
  // Outgoing descriptor
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      case (req.addr)
        ADDR_SEND_DESC_L, ADDR_REWR_DESC_L: out_desc.payload[31:0] <= desc_lo_new;
        ADDR_SEND_DESC_H, ADDR_REWR_DESC_H: out_desc.payload[59:32] <= desc_hi_new[27:0];
        ADDR_SEND_DESC_TYPE:                out_desc.dtype <= req.data[3:0];
        default: begin end
      endcase
    end
  end

  // Type write is the send strobe
  always_ff @(posedge clk) begin
    if (rst)
      out_desc_valid <= 1'b0;
    else if (wr_fire && (req.addr == ADDR_SEND_DESC_TYPE))
      out_desc_valid <= 1'b1;
    else if (out_desc_ready)
      out_desc_valid <= 1'b0;
  end

  //////////////////////////////
  // Configuration
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= CFG_RESET;
    end else if (wr_fire) begin
      case (req.addr)
        ADDR_TIMER_STEP: cfg.timer_step <= step_new;
        ADDR_INT_MASK:   cfg.int_mask   <= mask_new[INT_W-1:0];
        ADDR_BC_MASK:    cfg.bc_mask    <= req.data[BC_ADDR_W-1:0];
        ADDR_BC_EQUAL:   cfg.bc_equal   <= req.data[BC_ADDR_W-1:0];
        ADDR_BC_FIFO_EN: cfg.bc_fifo_en <= req.data[0];
        default: begin end
      endcase
    end
  end

  // Command strobes for the other blocks
  always_comb begin
    cmd.timer_restart = wr_fire && (req.addr == ADDR_TIMER_STEP);
    cmd.flag_wr       = wr_fire && (req.addr == ADDR_DRAM_FLAG_WR);
    cmd.flag_clr      = wr_fire && (req.addr == ADDR_DRAM_FLAG_CLR);
    cmd.int_ack       = wr_fire && (req.addr == ADDR_INT_ACK);
    cmd.bc_pop        = wr_fire && (req.addr == ADDR_BC_RD_STRB) && req.data[0];
    cmd.desc_release  = wr_fire && (req.addr == ADDR_RD_DESC_STRB) && req.data[0];
    cmd.data          = req.data;
    cmd.strb          = req.strb;
  end

  assign in_desc_taken = cmd.desc_release;

  // A descriptor on hold stays put until taken, a rewrite being the only way in
  a_desc_hold: assert property (@(posedge clk) disable iff (rst)
    (out_desc_valid && !out_desc_ready && !rewr_wr) |=> $stable(out_desc));

endmodule

//--- src/io_read_mux.sv
// I/O read decoder and registered response word
`timescale 1ns/1ps

module io_read_mux import core_io_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid,
  input  io_req_t              req,
  input  io_cfg_t              cfg,
  input  int_flags_t           flags,
  input  logic [WORD_W-1:0]    dram_flags,
  input  logic [BC_ADDR_W-1:0] bc_head,
  input  desc_t                in_desc,
  input  logic                 in_desc_valid,
  input  logic                 out_desc_ready,
  output logic                 rsp_valid,
  output logic [WORD_W-1:0]    rsp_data
);

  logic              rd_fire;
  logic [WORD_W-1:0] rd_word;

  // Reads never stall
  assign rd_fire = req_valid && !req.wr;

  always_comb begin
    rd_word = '0;
    case (req.addr)
      ADDR_RD_DESC_L:     if (in_desc_valid) rd_word = in_desc[31:0];
      ADDR_RD_DESC_H:     if (in_desc_valid) rd_word = in_desc[63:32];
      ADDR_RD_DRAM_FLAGS: rd_word = dram_flags;
      ADDR_RD_STATUS:     rd_word = {16'h0000, 7'd0, out_desc_ready, 7'd0, in_desc_valid};
      ADDR_RD_INT_FLAGS:  rd_word = {{(WORD_W-INT_W){1'b0}}, flags};
      ADDR_RD_MASK:       rd_word = {{(WORD_W-INT_W){1'b0}}, cfg.int_mask};
      ADDR_RD_BC_MASK:    rd_word = {{(WORD_W-BC_ADDR_W){1'b0}}, cfg.bc_mask};
      ADDR_RD_BC_EQUAL:   rd_word = {{(WORD_W-BC_ADDR_W){1'b0}}, cfg.bc_equal};
      ADDR_RD_BC_ADDR:    rd_word = {{(WORD_W-BC_ADDR_W){1'b0}}, bc_head};
      default: begin end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      rsp_valid <= 1'b0;
    else
      rsp_valid <= rd_fire;
  end

  always_ff @(posedge clk) begin
    if (rd_fire)
      rsp_data <= rd_word;
  end

endmodule

//--- src/interval_timer.sv
// Programmable interval timer with acknowledged interrupt
`timescale 1ns/1ps

module interval_timer import core_io_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  io_cfg_t cfg,
  input  io_cmd_t cmd,
  output logic    timer_irq
);

  logic [WORD_W-1:0] count;

  // Wraps at the step, so one interrupt every step+1 cycles
  always_ff @(posedge clk) begin
    if (rst || cmd.timer_restart) begin
      count     <= '0;
      timer_irq <= 1'b0;
    end else if (count == cfg.timer_step) begin
      count     <= '0;
      timer_irq <= 1'b1;
    end else begin
      count <= count + 1'b1;
      if (cmd.int_ack && cmd.data[INT_TIMER])
        timer_irq <= 1'b0;
    end
  end

endmodule

//--- src/dram_recv_flags.sv
// DRAM receive-tag flag word with software write and single-bit clear
`timescale 1ns/1ps

module dram_recv_flags import core_io_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [TAG_W-1:0]  recv_dram_tag,
  input  logic              recv_dram_tag_valid,
  input  io_cmd_t           cmd,
  output logic [WORD_W-1:0] flags
);

  logic [TAG_W-1:0]  tag_r;
  logic              tag_valid_r;
  logic [WORD_W-1:0] flags_next;

  // Tag input is registered for timing
  always_ff @(posedge clk) begin
    tag_r <= recv_dram_tag;
    if (rst)
      tag_valid_r <= 1'b0;
    else
      tag_valid_r <= recv_dram_tag_valid;
  end

  always_comb begin
    flags_next = flags;
    if (cmd.flag_wr)
      flags_next = apply_strb(flags, cmd.data, cmd.strb);
    if (cmd.flag_clr)
      flags_next[cmd.data[TAG_W-1:0]] = 1'b0;
    // Arriving tag beats a clear of the same bit
    if (tag_valid_r)
      flags_next[tag_r] = 1'b1;
    flags_next[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst)
      flags <= '0;
    else
      flags <= flags_next;
  end

endmodule

//--- src/bc_msg_filter.sv
// Broadcast message address filter feeding a FIFO, with overflow pulse
`timescale 1ns/1ps

module bc_msg_filter import core_io_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [BC_ADDR_W-1:0] bc_msg_addr,
  input  logic                 bc_msg_valid,
  input  io_cfg_t              cfg,
  input  io_cmd_t              cmd,
  output logic                 bc_pending,
  output logic [BC_ADDR_W-1:0] bc_head,
  output logic                 bc_overflow
);

  logic [BC_ADDR_W-1:0] msg_addr_r;
  logic                 msg_valid_r;
  logic                 fifo_ready;

  // Keep only addresses that match under the mask
  always_ff @(posedge clk) begin
    msg_addr_r <= bc_msg_addr;
    if (rst)
      msg_valid_r <= 1'b0;
    else
      msg_valid_r <= bc_msg_valid && cfg.bc_fifo_en &&
                     ((bc_msg_addr & cfg.bc_mask) == cfg.bc_equal);
  end

  sync_fifo #(
    .DEPTH (BC_FIFO_DEPTH),
    .WIDTH (BC_ADDR_W)
  ) bc_fifo (
    .clk        (clk),
    .rst        (rst),
    .clear      (!cfg.bc_fifo_en),
    .din_valid  (msg_valid_r),
    .din        (msg_addr_r),
    .din_ready  (fifo_ready),
    .dout_valid (bc_pending),
    .dout       (bc_head),
    .dout_ready (cmd.bc_pop)
  );

  // Message is dropped when the FIFO is full
  assign bc_overflow = msg_valid_r && !fifo_ready && cfg.bc_fifo_en;

endmodule

//--- src/irq_ctrl.sv
// Interrupt flag word, masking, sticky broadcast error and core interrupt
`timescale 1ns/1ps

module irq_ctrl import core_io_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              timer_irq,
  input  logic              in_desc_valid,
  input  logic [WORD_W-1:0] dram_flags,
  input  logic              bc_pending,
  input  logic              bc_overflow,
  input  logic              poke_int,
  input  io_cfg_t           cfg,
  input  io_cmd_t           cmd,
  output int_flags_t        flags,
  output logic              core_irq,
  output logic              poke_int_ack
);

  logic             bc_err;
  logic [INT_W-1:0] raw;

  // Held until software acks it
  always_ff @(posedge clk) begin
    if (rst)
      bc_err <= 1'b0;
    else
      bc_err <= !(cmd.int_ack && cmd.data[INT_BC_ERR]) && (bc_err || bc_overflow);
  end

  always_comb begin
    raw              = '0;
    raw[INT_TIMER]   = timer_irq;
    raw[INT_IN_DESC] = in_desc_valid;
    raw[INT_DRAM]    = |dram_flags;
    raw[INT_BC_MSG]  = bc_pending;
    raw[INT_POKE]    = poke_int;
    raw[INT_BC_ERR]  = bc_err;
  end

  assign flags = int_flags_t'(raw);

  // Dropped for a cycle on ack so the handler sees a clean edge
  always_ff @(posedge clk) begin
    if (rst)
      core_irq <= 1'b0;
    else
      core_irq <= !cmd.int_ack && |(raw & cfg.int_mask);
  end

  assign poke_int_ack = cmd.int_ack && cmd.data[INT_POKE];

endmodule

//--- src/core_io_top.sv
// Top level of the memory-mapped I/O block
`timescale 1ns/1ps

module core_io_top import core_io_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid,
  input  io_req_t              req,
  output logic                 req_ready,
  output logic                 rsp_valid,
  output logic [WORD_W-1:0]    rsp_data,
  output desc_t                out_desc,
  output logic                 out_desc_valid,
  input  logic                 out_desc_ready,
  input  desc_t                in_desc,
  input  logic                 in_desc_valid,
  output logic                 in_desc_taken,
  input  logic [TAG_W-1:0]     recv_dram_tag,
  input  logic                 recv_dram_tag_valid,
  input  logic [BC_ADDR_W-1:0] bc_msg_addr,
  input  logic                 bc_msg_valid,
  input  logic                 poke_int,
  output logic                 poke_int_ack,
  output logic                 core_irq
);

  io_cfg_t              cfg;
  io_cmd_t              cmd;
  int_flags_t           flags;
  logic                 timer_irq;
  logic [WORD_W-1:0]    dram_flags;
  logic                 bc_pending;
  logic [BC_ADDR_W-1:0] bc_head;
  logic                 bc_overflow;

  io_reg_file u_reg_file (
    .clk, .rst, .req_valid, .req, .req_ready,
    .out_desc, .out_desc_valid, .out_desc_ready,
    .cfg, .cmd, .in_desc_taken
  );

  io_read_mux u_read_mux (
    .clk, .rst, .req_valid, .req, .cfg, .flags, .dram_flags, .bc_head,
    .in_desc, .in_desc_valid, .out_desc_ready, .rsp_valid, .rsp_data
  );

  interval_timer u_timer (
    .clk, .rst, .cfg, .cmd, .timer_irq
  );

  dram_recv_flags u_dram_flags (
    .clk, .rst, .recv_dram_tag, .recv_dram_tag_valid, .cmd,
    .flags (dram_flags)
  );

  bc_msg_filter u_bc_filter (
    .clk, .rst, .bc_msg_addr, .bc_msg_valid, .cfg, .cmd,
    .bc_pending, .bc_head, .bc_overflow
  );

  irq_ctrl u_irq (
    .clk, .rst, .timer_irq, .in_desc_valid, .dram_flags, .bc_pending,
    .bc_overflow, .poke_int, .cfg, .cmd, .flags, .core_irq, .poke_int_ack
  );

endmodule

//--- tests/core_io_tb.sv
// Testbench for the I/O block: clock, reset, file-driven bus driver, compare tasks, watchdog
`timescale 1ns/1ps

module core_io_tb import core_io_pkg::*; ();

  localparam int PERIOD    = 40;
  localparam int QUARTER   = PERIOD / 4;
  localparam     STIM_FILE = "tests/core_io_stimulus.txt";

  logic                 clk;
  logic                 rst;
  logic                 req_valid;
  io_req_t              req;
  logic                 req_ready;
  logic                 rsp_valid;
  logic [WORD_W-1:0]    rsp_data;
  desc_t                out_desc;
  logic                 out_desc_valid;
  logic                 out_desc_ready;
  desc_t                in_desc;
  logic                 in_desc_valid;
  logic                 in_desc_taken;
  logic [TAG_W-1:0]     recv_dram_tag;
  logic                 recv_dram_tag_valid;
  logic [BC_ADDR_W-1:0] bc_msg_addr;
  logic                 bc_msg_valid;
  logic                 poke_int;
  logic                 poke_int_ack;
  logic                 core_irq;

  integer seed = 32'ha6235cde;
  integer rnd;
  int     ready_mode;
  logic   taken_seen;
  logic   ack_seen;
  int     errors;
  int     checks;
  int     tests;
  int     test_errors;
  int     test_checks;
  longint limit_ns;
  logic   armed;

  core_io_top DUT (.*);

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  // Descriptor sink: 0 holds low, 1 holds high, 2 follows a random sequence
  always @(negedge clk) begin
    if (ready_mode == 2) begin
      rnd = $random(seed);
      out_desc_ready = rnd[0];
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic tally(input bit ok);
    checks++;
    test_checks++;
    if (!ok) begin
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_word(input string what, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
    tally(got === exp);
    if (got !== exp)
      $display("ERROR at %0t ns: %0s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic check_desc(input string what, input desc_t got, input desc_t exp);
    tally(got === exp);
    if (got !== exp)
      $display("ERROR at %0t ns: %0s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    tally(got === exp);
    if (got !== exp)
      $display("ERROR at %0t ns: %0s is %b, expected %b", $time, what, got, exp);
  endtask

  //////////////////////////////
  // Bus and side-input drivers
  //////////////////////////////
  // Holds the request until it is taken; strobes are sampled mid-cycle
  task automatic complete_request();
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      #(QUARTER);
      accepted   = req_ready;
      taken_seen = in_desc_taken;
      ack_seen   = poke_int_ack;
      @(posedge clk);
      @(negedge clk);
    end
    req_valid = 1'b0;
  endtask

  task automatic drive_request(input logic wr, input logic [IO_ADDR_W-1:0] addr,
                               input logic [WORD_W-1:0] data, input logic [STRB_W-1:0] strb);
    @(negedge clk);
    req_valid = 1'b1;
    req.wr    = wr;
    req.addr  = addr;
    req.data  = data;
    req.strb  = strb;
  endtask

  task automatic bus_write(input logic [IO_ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
    drive_request(1'b1, addr, data, strb);
    complete_request();
  endtask

  // Response is due exactly one cycle after the read is taken
  task automatic bus_read(input logic [IO_ADDR_W-1:0] addr, input logic [WORD_W-1:0] exp);
    drive_request(1'b0, addr, '0, '0);
    complete_request();
    if (!rsp_valid) begin
      $display("Read of address %h got no response one cycle after it was accepted", addr);
      tally(1'b0);
    end else begin
      check_word($sformatf("read of address %h", addr), rsp_data, exp);
    end
  endtask

  // Send write against a held descriptor, then release the sink
  task automatic stalled_write(input logic [IO_ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                               input int cycles);
    drive_request(1'b1, addr, data, '1);
    repeat (cycles) begin
      #(QUARTER);
      check_bit("req_ready while the descriptor is held", req_ready, 1'b0);
      @(negedge clk);
    end
    ready_mode     = 1;
    out_desc_ready = 1'b1;
    complete_request();
  endtask

  task automatic pulse_tag(input logic [TAG_W-1:0] tag);
    @(negedge clk);
    recv_dram_tag       = tag;
    recv_dram_tag_valid = 1'b1;
    @(negedge clk);
    recv_dram_tag_valid = 1'b0;
  endtask

  // Back-to-back messages with rising addresses
  task automatic send_messages(input logic [BC_ADDR_W-1:0] first, input int count);
    int i;
    for (i = 0; i < count; i++) begin
      @(negedge clk);
      bc_msg_addr  = first + i[BC_ADDR_W-1:0];
      bc_msg_valid = 1'b1;
    end
    @(negedge clk);
    bc_msg_valid = 1'b0;
  endtask

  task automatic set_input(input logic [8*16-1:0] name, input logic [63:0] value);
    @(negedge clk);
    case (name)
      "odr": begin
        ready_mode = int'(value[1:0]);
        if (value[1:0] != 2'd2)
          out_desc_ready = value[0];
      end
      "ind":  in_desc = desc_t'(value);
      "idv":  in_desc_valid = value[0];
      "poke": poke_int = value[0];
      default: begin
        $display("Unknown side input %0s in the stimulus file", name);
        tally(1'b0);
      end
    endcase
  endtask

  task automatic check_output(input logic [8*16-1:0] name, input logic exp);
    case (name)
      "irq":   check_bit("core_irq", core_irq, exp);
      "odv":   check_bit("out_desc_valid", out_desc_valid, exp);
      "taken": check_bit("in_desc_taken on the last write", taken_seen, exp);
      "pack":  check_bit("poke_int_ack on the last write", ack_seen, exp);
      default: begin
        $display("Unknown output %0s in the stimulus file", name);
        tally(1'b0);
      end
    endcase
  endtask

  task automatic report_test(input logic [8*16-1:0] name);
    tests++;
    $display("Test %0d %0s: %0d checks, %0d errors", tests, name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  //////////////////////////////
  // Stimulus file
  //////////////////////////////
  task automatic scan_length(input int fd, output longint cycles);
    logic [8*16-1:0]  op;
    logic [8*128-1:0] rest;
    logic [63:0]      n;
    int               r;
    cycles = 0;
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "wait") begin
        r = $fscanf(fd, "%h", n);
        cycles += n;
      end
      if (op != "#")
        cycles += 50;
      r = $fgets(rest, fd);
    end
  endtask

  task automatic run_stimulus(input int fd);
    logic [8*16-1:0]  op;
    logic [8*16-1:0]  name;
    logic [8*128-1:0] rest;
    logic [63:0]      a1;
    logic [63:0]      a2;
    logic [63:0]      a3;
    int               r;
    while ($fscanf(fd, "%s", op) == 1) begin
      case (op)
        "#": r = $fgets(rest, fd);
        "wr": begin
          r = $fscanf(fd, "%h %h %h", a1, a2, a3);
          bus_write(a1[IO_ADDR_W-1:0], a2[WORD_W-1:0], a3[STRB_W-1:0]);
        end
        "rd": begin
          r = $fscanf(fd, "%h %h", a1, a2);
          bus_read(a1[IO_ADDR_W-1:0], a2[WORD_W-1:0]);
        end
        "stall": begin
          r = $fscanf(fd, "%h %h %h", a1, a2, a3);
          stalled_write(a1[IO_ADDR_W-1:0], a2[WORD_W-1:0], int'(a3));
        end
        "dsc": begin
          r = $fscanf(fd, "%h", a1);
          check_desc("out_desc", out_desc, desc_t'(a1));
        end
        "bit": begin
          r = $fscanf(fd, "%s %h", name, a2);
          check_output(name, a2[0]);
        end
        "set": begin
          r = $fscanf(fd, "%s %h", name, a2);
          set_input(name, a2);
        end
        "tag": begin
          r = $fscanf(fd, "%h", a1);
          pulse_tag(a1[TAG_W-1:0]);
        end
        "bc": begin
          r = $fscanf(fd, "%h %h", a1, a2);
          send_messages(a1[BC_ADDR_W-1:0], int'(a2));
        end
        "wait": begin
          r = $fscanf(fd, "%h", a1);
          repeat (int'(a1)) @(negedge clk);
        end
        "end": begin
          r = $fscanf(fd, "%s", name);
          report_test(name);
        end
        default: begin
          $display("Unknown operation %0s in the stimulus file", op);
          tally(1'b0);
          r = $fgets(rest, fd);
        end
      endcase
    end
  endtask

  //////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////
  initial begin
    int fd;
    rst                 = 1'b1;
    req_valid           = 1'b0;
    req                 = '0;
    out_desc_ready      = 1'b0;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    recv_dram_tag       = '0;
    recv_dram_tag_valid = 1'b0;
    bc_msg_addr         = '0;
    bc_msg_valid        = 1'b0;
    poke_int            = 1'b0;
    ready_mode          = 0;
    taken_seen          = 1'b0;
    ack_seen            = 1'b0;
    errors              = 0;
    checks              = 0;
    tests               = 0;
    test_errors         = 0;
    test_checks         = 0;
    armed               = 1'b0;

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %0s", STIM_FILE);
      errors++;
    end else begin
      scan_length(fd, limit_ns);
      $fclose(fd);
      limit_ns = limit_ns * PERIOD;
      armed    = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      fd = $fopen(STIM_FILE, "r");
      run_stimulus(fd);
      $fclose(fd);
    end

    $display("Done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  initial begin
    wait (armed);
    #(limit_ns);
    $display("Timeout: the stimulus did not finish within %0d ns", limit_ns);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- tests/core_io_stimulus.txt
# Columns: op arg1 arg2 arg3, every number in hex
# wr addr data strb | rd addr expect | stall addr data cycles | dsc expect | bit name expect
# set name value | tag id | bc first_addr count | wait cycles | end test_name
rd    27 00000000
wr    07 ffffffff f
rd    28 0000011e
bit   irq 0
end   reset_state
wr    02 89abcdef f
wr    03 01234567 f
wr    0a 00000005 f
bit   odv 1
dsc   5123456789abcdef
stall 02 00000000 4
bit   odv 0
dsc   5123456700000000
set   odr 2
wr    03 0aaaaaaa f
wr    0a 00000003 f
dsc   3aaaaaaa00000000
set   odr 0
wr    16 11112222 f
dsc   3aaaaaaa11112222
set   odr 1
end   out_desc
set   ind 0123456789abcdef
set   idv 1
rd    20 89abcdef
rd    21 01234567
rd    23 00000101
wr    0b 00000001 f
bit   taken 1
wr    0b 00000000 f
bit   taken 0
set   idv 0
rd    20 00000000
rd    21 00000000
end   in_desc
tag   05
tag   00
tag   1f
rd    22 80000020
rd    27 00000004
bit   irq 1
wr    08 ffffff00 2
rd    22 8000ff20
wr    0c 00000005 f
rd    22 8000ff00
wr    08 00000000 f
rd    22 00000000
rd    27 00000000
bit   irq 0
end   dram_flags
wr    12 00007f00 f
wr    13 00001200 f
wr    14 00000001 f
bc    1234 1
bc    5634 1
bc    12ab 1
rd    27 00000008
rd    34 00001234
wr    15 00000001 f
rd    34 000012ab
wr    15 00000001 f
rd    27 00000000
bc    1200 11
rd    27 00000108
wr    0f 00000100 f
rd    27 00000008
wr    14 00000000 f
rd    27 00000000
end   bc_filter
wr    07 00000014 f
wait  19
rd    27 00000001
bit   irq 0
wr    0e 0000011f f
wait  1
bit   irq 1
set   poke 1
wr    0f 00000011 f
bit   pack 1
bit   irq 0
set   poke 0
rd    27 00000000
end   timer_poke

//--- project.f
src/core_io_pkg.sv
src/sync_fifo.sv
src/io_reg_file.sv
src/io_read_mux.sv
src/interval_timer.sv
src/dram_recv_flags.sv
src/bc_msg_filter.sv
src/irq_ctrl.sv
src/core_io_top.sv
tests/core_io_tb.sv
